//--- hdl/ftdi_cmd_defines.svh
`ifndef FTDI_CMD_DEFINES_SVH
`define FTDI_CMD_DEFINES_SVH

// Register map, 6-bit addresses from the command header
`define GAIN_ADDR     6'd0
`define SETTINGS_ADDR 6'd1
`define STATUS_ADDR   6'd2  // Read only
`define ADCDATA_ADDR  6'd3  // Streams the sample FIFO
`define ECHO_ADDR     6'd4
`define EXTFREQ_ADDR  6'd5  // Read only, snapshot at read start
`define PHASE_ADDR    6'd9
`define SAMPLES_ADDR  6'd16
`define OFFSET_ADDR   6'd26

// Natural sizes in bytes, used when the length field is zero
`define EXTFREQ_LEN 16'd4
`define PHASE_LEN   16'd2
`define SAMPLES_LEN 16'd4
`define OFFSET_LEN  16'd4

// Datapath widths
`define ADDR_W  6
`define BYTE_W  8
`define LEN_W   16
`define WORD_W  32
`define PHASE_W 9

// Settings register bit positions
`define SET_RESET_BIT    0  // Soft reset
`define SET_HILOW_BIT    1  // Amplifier hilo
`define SET_TRIGMODE_BIT 2  // Trigger polarity
`define SET_ARM_BIT      3
`define SET_PLLRST_BIT   4  // Stored, no output on this board
`define SET_TRIGWAIT_BIT 5  // Wait for inactive trigger before arming
`define SET_ADCCLK_BIT   6  // ADC clock source
`define SET_TRIGSRC_BIT  7  // 1 internal, 0 external

`endif

//--- hdl/ftdi_cmd_pkg.sv
`include "ftdi_cmd_defines.svh"
`default_nettype none

package ftdi_cmd_pkg;

	// First byte of every command
	typedef struct packed {
		logic              valid;  // Bit 7, clear means drop
		logic              write;  // Bit 6, 1 write / 0 read
		logic [`ADDR_W-1:0] addr;
	} cmd_hdr_t;

	typedef enum logic [3:0] {
		IDLE,
		HDR,
		LEN_LSB,
		LEN_MSB,
		WR_WAIT,   // Data bytes from host
		RD_SEND,   // Register bytes to host
		ADC_REQ,   // Pop a sample
		ADC_SEND   // Send the popped sample
	} cmd_state_e;

	// One register access, byte at a time
	typedef struct packed {
		logic               wr_en;
		logic               rd_start;
		logic [`ADDR_W-1:0] addr;
		logic [8:0]         byte_idx;
		logic [`BYTE_W-1:0] wdata;
	} reg_access_t;

	// Settings byte, MSB first
	typedef struct packed {
		logic trig_src;
		logic adc_clk_src;
		logic trig_wait;
		logic pll_rst;
		logic arm;
		logic trig_mode;
		logic hilow;
		logic soft_reset;
	} settings_t;

	typedef struct packed {
		logic               arm;
		logic               mode;
		logic               trig_wait;
		logic               source;
		logic [`WORD_W-1:0] offset;  // Trigger to capture start, clocks
	} trig_ctrl_t;

	typedef struct packed {
		logic [`PHASE_W-1:0] value;
		logic                load;  // One-cycle strobe
	} phase_ctrl_t;

	// Length used when the host sends zero
	function automatic logic [`LEN_W-1:0] natural_len(input logic [`ADDR_W-1:0] addr);
		case (addr)
			`EXTFREQ_ADDR: natural_len = `EXTFREQ_LEN;
			`PHASE_ADDR:   natural_len = `PHASE_LEN;
			`SAMPLES_ADDR: natural_len = `SAMPLES_LEN;
			`OFFSET_ADDR:  natural_len = `OFFSET_LEN;
			default:       natural_len = 16'd1;  // Single byte or unknown
		endcase
	endfunction

endpackage

`default_nettype wire

//--- hdl/cmd_fsm.sv
`timescale 1ns/1ps
`include "ftdi_cmd_defines.svh"
`default_nettype none

module cmd_fsm (
	input  wire logic                       ftdi_clk,
	input  wire logic                       reset,
	input  wire logic                       rxf_i,
	input  wire logic                       txe_i,
	input  wire logic [`BYTE_W-1:0]         din_i,
	output logic                            rd_o,
	output logic                            wr_o,
	output logic                            isout_o,
	output logic [`BYTE_W-1:0]              dout_o,
	input  wire logic                       fifo_empty_i,
	input  wire logic [`BYTE_W-1:0]         fifo_data_i,
	output logic                            fifo_rd_o,
	input  wire logic [8:0]                 byte_idx_i,
	input  wire logic                       last_i,
	output logic                            cnt_load_o,
	output logic                            cnt_step_o,
	output logic [`LEN_W-1:0]               cnt_len_o,
	output ftdi_cmd_pkg::reg_access_t       access_o,
	input  wire logic [`BYTE_W-1:0]         rdata_i
);

	ftdi_cmd_pkg::cmd_state_e state_q;
	ftdi_cmd_pkg::cmd_hdr_t   hdr_q;
	ftdi_cmd_pkg::cmd_hdr_t   hdr_in;   // Header view of din_i
	logic [`BYTE_W-1:0]       len_lsb_q;
	logic [`BYTE_W-1:0]       dout_q;
	logic                     isout_q;
	logic                     pend_q;   // dout_q holds a byte not yet taken
	logic                     rd_want;
	logic                     len_done;
	logic                     is_adc;
	logic [`LEN_W-1:0]        len_raw;
	logic [`LEN_W-1:0]        len_final;

	assign hdr_in = ftdi_cmd_pkg::cmd_hdr_t'(din_i);
	assign is_adc = hdr_q.addr == `ADCDATA_ADDR;

	// Every state that takes a host byte
	assign rd_want = (state_q == ftdi_cmd_pkg::HDR) || (state_q == ftdi_cmd_pkg::LEN_LSB) ||
		(state_q == ftdi_cmd_pkg::LEN_MSB) || (state_q == ftdi_cmd_pkg::WR_WAIT);
	assign rd_o    = rd_want & rxf_i;   // Bridge flow control
	assign wr_o    = pend_q & txe_i;
	assign isout_o = isout_q;
	assign dout_o  = dout_q;

	// Length is little endian, zero picks the natural size
	assign len_raw   = {din_i, len_lsb_q};
	assign len_final = (len_raw == '0) ? ftdi_cmd_pkg::natural_len(hdr_q.addr) : len_raw;
	assign len_done  = (state_q == ftdi_cmd_pkg::LEN_MSB) & rd_o;

	assign cnt_load_o = len_done;
	assign cnt_len_o  = len_final;
	assign cnt_step_o = ((state_q == ftdi_cmd_pkg::WR_WAIT) & rd_o) |
		((state_q == ftdi_cmd_pkg::RD_SEND) & wr_o);

	// Pop only when the bridge could also take a byte
	assign fifo_rd_o = (state_q == ftdi_cmd_pkg::ADC_REQ) & txe_i & ~fifo_empty_i;

	assign access_o = '{
		wr_en:    (state_q == ftdi_cmd_pkg::WR_WAIT) & rd_o,
		rd_start: len_done & ~hdr_q.write,   // Also freezes the frequency snapshot
		addr:     hdr_q.addr,
		byte_idx: byte_idx_i,
		wdata:    din_i
	};

	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			state_q <= ftdi_cmd_pkg::IDLE;
			hdr_q   <= '0;
			isout_q <= 1'b0;
			pend_q  <= 1'b0;
		end else begin
			case (state_q)
				ftdi_cmd_pkg::IDLE: if (rxf_i) state_q <= ftdi_cmd_pkg::HDR;
				ftdi_cmd_pkg::HDR: begin
					if (rd_o) begin
						hdr_q   <= hdr_in;
						// Bit 7 clear drops the byte
						state_q <= hdr_in.valid ? ftdi_cmd_pkg::LEN_LSB : ftdi_cmd_pkg::IDLE;
					end
				end
				ftdi_cmd_pkg::LEN_LSB: if (rd_o) state_q <= ftdi_cmd_pkg::LEN_MSB;
				ftdi_cmd_pkg::LEN_MSB: begin
					if (rd_o) begin
						if (hdr_q.write) begin
							state_q <= ftdi_cmd_pkg::WR_WAIT;
						end else begin
							isout_q <= 1'b1;  // Turn the bus around
							state_q <= is_adc ? ftdi_cmd_pkg::ADC_REQ : ftdi_cmd_pkg::RD_SEND;
						end
					end
				end
				ftdi_cmd_pkg::WR_WAIT: if (rd_o && last_i) state_q <= ftdi_cmd_pkg::IDLE;
				ftdi_cmd_pkg::RD_SEND: begin
					if (!pend_q) begin
						pend_q <= 1'b1;   // rdata_i loaded this cycle
					end else if (txe_i) begin
						pend_q <= 1'b0;
						if (last_i) begin
							isout_q <= 1'b0;
							state_q <= ftdi_cmd_pkg::IDLE;
						end
					end
				end
				ftdi_cmd_pkg::ADC_REQ: begin
					if (txe_i) begin
						if (fifo_empty_i) begin
							isout_q <= 1'b0;  // Stream drained
							state_q <= ftdi_cmd_pkg::IDLE;
						end else begin
							state_q <= ftdi_cmd_pkg::ADC_SEND;
						end
					end
				end
				ftdi_cmd_pkg::ADC_SEND: begin
					if (!pend_q) begin
						pend_q <= 1'b1;   // Sample valid one cycle after pop
					end else if (txe_i) begin
						pend_q  <= 1'b0;
						state_q <= ftdi_cmd_pkg::ADC_REQ;
					end
				end
				default: state_q <= ftdi_cmd_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge ftdi_clk) begin
		if ((state_q == ftdi_cmd_pkg::LEN_LSB) && rd_o) len_lsb_q <= din_i;
		if (!pend_q) begin
			if (state_q == ftdi_cmd_pkg::RD_SEND) dout_q <= rdata_i;
			else if (state_q == ftdi_cmd_pkg::ADC_SEND) dout_q <= fifo_data_i;
		end
	end

endmodule

`default_nettype wire

//--- hdl/byte_counter.sv
`timescale 1ns/1ps
`include "ftdi_cmd_defines.svh"
`default_nettype none

module byte_counter (
	input  wire logic              ftdi_clk,
	input  wire logic              reset,
	input  wire logic              load_i,
	input  wire logic [`LEN_W-1:0] len_i,
	input  wire logic              step_i,
	output logic [8:0]             idx_o,
	output logic                   last_o
);

	logic [`LEN_W-1:0] remain_q;  // Bytes left including the current one
	logic [8:0]        idx_q;

	// Byte lane index for the registers
	// Saturates, lanes that far out read zero anyway
	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			remain_q <= '0;
			idx_q    <= '0;
		end else if (load_i) begin
			remain_q <= len_i;
			idx_q    <= '0;
		end else if (step_i) begin
			if (remain_q != '0) remain_q <= remain_q - 1'b1;
			if (idx_q != '1) idx_q <= idx_q + 1'b1;
		end
	end

	assign idx_o  = idx_q;
	assign last_o = remain_q <= 16'd1;  // Tracks the full 16-bit length

endmodule

`default_nettype wire

//--- hdl/ctrl_regs.sv
`timescale 1ns/1ps
`include "ftdi_cmd_defines.svh"
`default_nettype none

module ctrl_regs (
	input  wire logic                        ftdi_clk,
	input  wire logic                        reset,
	input  wire ftdi_cmd_pkg::reg_access_t   access_i,
	output logic [`BYTE_W-1:0]               rdata_o,
	input  wire logic [`BYTE_W-1:0]          status_i,
	input  wire logic [`WORD_W-1:0]          extclk_freq_i,
	input  wire logic [`WORD_W-1:0]          maxsamples_i,
	input  wire logic [`PHASE_W-1:0]         phase_i,
	input  wire logic                        phase_done_i,
	output logic [`BYTE_W-1:0]               gain_o,
	output logic                             hilow_o,
	output logic                             adc_clk_src_o,
	output logic                             reset_o,
	output logic [`WORD_W-1:0]               maxsamples_o,
	output ftdi_cmd_pkg::trig_ctrl_t         trig_o,
	output ftdi_cmd_pkg::phase_ctrl_t        phase_o
);

	localparam int WORD_BYTES = `WORD_W / `BYTE_W;

	logic [`BYTE_W-1:0]      gain_q;
	logic [`BYTE_W-1:0]      echo_q;
	ftdi_cmd_pkg::settings_t settings_q;
	logic [`WORD_W-1:0]      samples_q;
	logic [`WORD_W-1:0]      offset_q;
	logic [`WORD_W-1:0]      freq_q;      // Frozen copy for coherent bytes
	logic [`PHASE_W-1:0]     phase_val_q;
	logic [`PHASE_W-1:0]     phase_in_q;
	logic                    phase_ld_q;
	logic                    phase_done_q;
	logic                    soft_q;      // Soft reset pulse
	logic                    lane0;
	logic                    in_word;
	logic [1:0]              lane;
	logic [`BYTE_W-1:0]      wdata;

	assign lane0   = access_i.byte_idx == '0;
	assign in_word = access_i.byte_idx < WORD_BYTES;
	assign lane    = access_i.byte_idx[1:0];
	assign wdata   = access_i.wdata;

	// Hard reset async, soft reset one clock after the settings bit
	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			gain_q     <= '0;
			settings_q <= '0;
			samples_q  <= maxsamples_i;  // Full capture depth
			offset_q   <= '0;
		end else if (soft_q) begin
			gain_q     <= '0;
			settings_q <= '0;
			samples_q  <= maxsamples_i;
			offset_q   <= '0;
		end else if (access_i.wr_en) begin
			case (access_i.addr)
				`GAIN_ADDR: if (lane0) gain_q <= wdata;
				`SETTINGS_ADDR: begin
					if (lane0) begin
						settings_q.soft_reset  <= wdata[`SET_RESET_BIT];
						settings_q.hilow       <= wdata[`SET_HILOW_BIT];
						settings_q.trig_mode   <= wdata[`SET_TRIGMODE_BIT];
						settings_q.arm         <= wdata[`SET_ARM_BIT];
						settings_q.pll_rst     <= wdata[`SET_PLLRST_BIT];
						settings_q.trig_wait   <= wdata[`SET_TRIGWAIT_BIT];
						settings_q.adc_clk_src <= wdata[`SET_ADCCLK_BIT];
						settings_q.trig_src    <= wdata[`SET_TRIGSRC_BIT];
					end
				end
				`SAMPLES_ADDR: if (in_word) samples_q[lane*8 +: 8] <= wdata;
				`OFFSET_ADDR:  if (in_word) offset_q[lane*8 +: 8] <= wdata;
				default: ;  // Read only or unknown
			endcase
		end
	end

	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			soft_q       <= 1'b0;
			phase_ld_q   <= 1'b0;
			phase_done_q <= 1'b0;
			phase_in_q   <= '0;
		end else begin
			soft_q     <= settings_q.soft_reset & ~soft_q;  // Single cycle
			// Byte 1 bit 1 starts the phase shift
			phase_ld_q <= access_i.wr_en && (access_i.addr == `PHASE_ADDR) &&
				(access_i.byte_idx == 9'd1) && wdata[1];
			if (phase_ld_q) begin
				phase_done_q <= 1'b0;   // New shift pending
				phase_in_q   <= '0;
			end else if (phase_done_i) begin
				phase_done_q <= 1'b1;
				phase_in_q   <= phase_i;
			end
		end
	end

	always_ff @(posedge ftdi_clk) begin
		if (access_i.wr_en && lane0 && (access_i.addr == `ECHO_ADDR)) echo_q <= wdata;
		if (access_i.wr_en && (access_i.addr == `PHASE_ADDR)) begin
			if (lane0) phase_val_q[7:0] <= wdata;
			else if (access_i.byte_idx == 9'd1) phase_val_q[8] <= wdata[0];  // P8
		end
		if (access_i.rd_start) freq_q <= extclk_freq_i;
	end

	// Read mux, lanes past the natural size give zero
	always_comb begin
		rdata_o = '0;
		case (access_i.addr)
			`GAIN_ADDR:     if (lane0) rdata_o = gain_q;
			`SETTINGS_ADDR: if (lane0) rdata_o = settings_q;
			`STATUS_ADDR:   if (lane0) rdata_o = status_i;
			`ECHO_ADDR:     if (lane0) rdata_o = echo_q;
			`EXTFREQ_ADDR:  if (in_word) rdata_o = freq_q[lane*8 +: 8];
			`PHASE_ADDR: begin
				if (lane0) rdata_o = phase_in_q[7:0];
				else if (access_i.byte_idx == 9'd1) rdata_o = {6'd0, phase_done_q, phase_in_q[8]};
			end
			`SAMPLES_ADDR:  if (in_word) rdata_o = samples_q[lane*8 +: 8];
			`OFFSET_ADDR:   if (in_word) rdata_o = offset_q[lane*8 +: 8];
			default:        rdata_o = '0;
		endcase
	end

	assign gain_o        = gain_q;
	assign hilow_o       = settings_q.hilow;
	assign adc_clk_src_o = settings_q.adc_clk_src;
	assign reset_o       = soft_q;
	assign maxsamples_o  = samples_q;
	assign trig_o = '{
		arm:       settings_q.arm,
		mode:      settings_q.trig_mode,
		trig_wait: settings_q.trig_wait,
		source:    settings_q.trig_src,
		offset:    offset_q
	};
	assign phase_o = '{value: phase_val_q, load: phase_ld_q};

endmodule

`default_nettype wire

//--- hdl/usb_cmd_top.sv
`timescale 1ns/1ps
`include "ftdi_cmd_defines.svh"
`default_nettype none

module usb_cmd_top (
	input  wire logic                  ftdi_clk,
	input  wire logic                  reset,
	input  wire logic                  rxf_i,
	input  wire logic                  txe_i,
	input  wire logic [`BYTE_W-1:0]    din_i,
	output logic                       rd_o,
	output logic                       wr_o,
	output logic                       isout_o,
	output logic [`BYTE_W-1:0]         dout_o,
	input  wire logic                  fifo_empty_i,
	input  wire logic [`BYTE_W-1:0]    fifo_data_i,
	output logic                       fifo_rd_o,
	input  wire logic [`BYTE_W-1:0]    status_i,
	input  wire logic [`WORD_W-1:0]    extclk_freq_i,
	input  wire logic [`WORD_W-1:0]    maxsamples_i,
	input  wire logic [`PHASE_W-1:0]   phase_i,
	input  wire logic                  phase_done_i,
	output logic [`BYTE_W-1:0]         gain_o,
	output logic                       hilow_o,
	output logic                       adc_clk_src_o,
	output logic                       reset_o,
	output logic [`WORD_W-1:0]         maxsamples_o,
	output ftdi_cmd_pkg::trig_ctrl_t   trig_o,
	output ftdi_cmd_pkg::phase_ctrl_t  phase_o
);

	logic [8:0]                byte_idx;
	logic                      last;
	logic                      cnt_load;
	logic                      cnt_step;
	logic [`LEN_W-1:0]         cnt_len;
	ftdi_cmd_pkg::reg_access_t access;   // FSM to register file
	logic [`BYTE_W-1:0]        rdata;

	cmd_fsm u_fsm (
		.ftdi_clk     (ftdi_clk),
		.reset        (reset),
		.rxf_i        (rxf_i),
		.txe_i        (txe_i),
		.din_i        (din_i),
		.rd_o         (rd_o),
		.wr_o         (wr_o),
		.isout_o      (isout_o),
		.dout_o       (dout_o),
		.fifo_empty_i (fifo_empty_i),
		.fifo_data_i  (fifo_data_i),
		.fifo_rd_o    (fifo_rd_o),
		.byte_idx_i   (byte_idx),
		.last_i       (last),
		.cnt_load_o   (cnt_load),
		.cnt_step_o   (cnt_step),
		.cnt_len_o    (cnt_len),
		.access_o     (access),
		.rdata_i      (rdata)
	);

	byte_counter u_cnt (
		.ftdi_clk (ftdi_clk),
		.reset    (reset),
		.load_i   (cnt_load),
		.len_i    (cnt_len),
		.step_i   (cnt_step),
		.idx_o    (byte_idx),
		.last_o   (last)
	);

	ctrl_regs u_regs (
		.ftdi_clk      (ftdi_clk),
		.reset         (reset),
		.access_i      (access),
		.rdata_o       (rdata),
		.status_i      (status_i),
		.extclk_freq_i (extclk_freq_i),
		.maxsamples_i  (maxsamples_i),
		.phase_i       (phase_i),
		.phase_done_i  (phase_done_i),
		.gain_o        (gain_o),
		.hilow_o       (hilow_o),
		.adc_clk_src_o (adc_clk_src_o),
		.reset_o       (reset_o),
		.maxsamples_o  (maxsamples_o),
		.trig_o        (trig_o),
		.phase_o       (phase_o)
	);

endmodule

`default_nettype wire

//--- verification/usb_cmd_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module usb_cmd_asserts (
	input wire logic                     ftdi_clk,
	input wire logic                     reset,
	input wire logic                     rxf_i,
	input wire logic                     txe_i,
	input wire logic                     rd_o,
	input wire logic                     wr_o,
	input wire logic                     isout_o,
	input wire ftdi_cmd_pkg::cmd_state_e state_q
);

	// Bridge flow control
	wr_needs_txe: assert property (@(posedge ftdi_clk) disable iff (reset) wr_o |-> txe_i)
		else $error("wr_o high while txe_i is low");

	rd_needs_rxf: assert property (@(posedge ftdi_clk) disable iff (reset) rd_o |-> rxf_i)
		else $error("rd_o high while rxf_i is low");

	// Sends only with the bus turned around
	wr_needs_isout: assert property (@(posedge ftdi_clk) disable iff (reset) wr_o |-> isout_o)
		else $error("wr_o high while isout_o is low");

	idle_is_input: assert property (@(posedge ftdi_clk) disable iff (reset)
		(state_q == ftdi_cmd_pkg::IDLE) |-> !isout_o)
		else $error("isout_o high in IDLE");

endmodule

bind cmd_fsm usb_cmd_asserts u_asserts (
	.ftdi_clk (ftdi_clk),
	.reset    (reset),
	.rxf_i    (rxf_i),
	.txe_i    (txe_i),
	.rd_o     (rd_o),
	.wr_o     (wr_o),
	.isout_o  (isout_o),
	.state_q  (state_q)
);

`default_nettype wire

//--- verification/usb_cmd_tb.sv
`timescale 1ns/1ps
`include "ftdi_cmd_defines.svh"
`default_nettype none

module usb_cmd_tb;

	localparam int TEST_BYTES  = 120;                            // Host plus returned bytes
	localparam int WATCHDOG_NS = (TEST_BYTES * 20 + 10) * 10;    // 20 cycles a byte
	localparam logic [31:0] MAXSAMPLES_A = 32'h0001_2345;
	localparam logic [31:0] MAXSAMPLES_B = 32'h0000_8000;        // Reloaded by soft reset

	logic                      ftdi_clk;
	logic                      reset;
	logic                      rxf_i;
	logic                      txe_i;
	logic [`BYTE_W-1:0]        din_i;
	logic                      rd_o;
	logic                      wr_o;
	logic                      isout_o;
	logic [`BYTE_W-1:0]        dout_o;
	logic                      fifo_empty_i;
	logic [`BYTE_W-1:0]        fifo_data_i;
	logic                      fifo_rd_o;
	logic [`BYTE_W-1:0]        status_i;
	logic [`WORD_W-1:0]        extclk_freq_i;
	logic [`WORD_W-1:0]        maxsamples_i;
	logic [`PHASE_W-1:0]       phase_i;
	logic                      phase_done_i;
	logic [`BYTE_W-1:0]        gain_o;
	logic                      hilow_o;
	logic                      adc_clk_src_o;
	logic                      reset_o;
	logic [`WORD_W-1:0]        maxsamples_o;
	ftdi_cmd_pkg::trig_ctrl_t  trig_o;
	ftdi_cmd_pkg::phase_ctrl_t phase_o;

	logic [7:0]                host_q[$];   // Bytes waiting in the bridge
	logic [7:0]                sent_q[$];   // Bytes taken from dout_o
	logic [7:0]                adc_q[$];    // Sample FIFO contents
	logic [7:0]                adc_next;    // Popped sample, out next cycle
	logic [31:0]               lcg_state = 32'h0867_0718;
	int                        err_cnt;
	int                        check_cnt;
	int                        test_cnt;
	int                        load_cnt;
	int                        soft_cnt;
	ftdi_cmd_pkg::phase_ctrl_t load_seen;

	usb_cmd_top uut (
		.ftdi_clk      (ftdi_clk),
		.reset         (reset),
		.rxf_i         (rxf_i),
		.txe_i         (txe_i),
		.din_i         (din_i),
		.rd_o          (rd_o),
		.wr_o          (wr_o),
		.isout_o       (isout_o),
		.dout_o        (dout_o),
		.fifo_empty_i  (fifo_empty_i),
		.fifo_data_i   (fifo_data_i),
		.fifo_rd_o     (fifo_rd_o),
		.status_i      (status_i),
		.extclk_freq_i (extclk_freq_i),
		.maxsamples_i  (maxsamples_i),
		.phase_i       (phase_i),
		.phase_done_i  (phase_done_i),
		.gain_o        (gain_o),
		.hilow_o       (hilow_o),
		.adc_clk_src_o (adc_clk_src_o),
		.reset_o       (reset_o),
		.maxsamples_o  (maxsamples_o),
		.trig_o        (trig_o),
		.phase_o       (phase_o)
	);

	initial begin
		ftdi_clk = 1'b0;
		forever #5 ftdi_clk = ~ftdi_clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Bridge and ADC FIFO, inputs on the falling edge, handshakes 1 ns before the rising edge
	initial begin : bridge_model
		logic [31:0] rnd;
		rxf_i        = 1'b0;
		txe_i        = 1'b0;
		din_i        = '0;
		fifo_empty_i = 1'b1;
		fifo_data_i  = '0;
		adc_next     = '0;
		forever begin
			@(negedge ftdi_clk);
			rnd          = next_rand();
			rxf_i        = host_q.size() != 0;
			din_i        = (host_q.size() != 0) ? host_q[0] : 8'h00;
			txe_i        = rnd[31:30] != 2'b00;  // Stalls about one cycle in four
			fifo_empty_i = adc_q.size() == 0;
			fifo_data_i  = adc_next;             // One cycle after the pop
			#4;
			if (rd_o) void'(host_q.pop_front());
			if (wr_o) sent_q.push_back(dout_o);
			if (fifo_rd_o) adc_next = adc_q.pop_front();
		end
	end

	// One-cycle strobes
	always @(negedge ftdi_clk) begin
		if (phase_o.load) begin
			load_cnt++;
			load_seen = phase_o;
		end
		if (reset_o) soft_cnt++;
	end

	task automatic compare_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("** Error @ %0t: %s got 8'h%02h, expected 8'h%02h", $time, what, got, exp);
		end
	endtask

	task automatic compare_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("** Error @ %0t: %s got 32'h%08h, expected 32'h%08h", $time, what, got, exp);
		end
	endtask

	task automatic compare_trig(input ftdi_cmd_pkg::trig_ctrl_t got,
		input ftdi_cmd_pkg::trig_ctrl_t exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("** Error @ %0t: trig_o got {%b%b%b%b, %h}, expected {%b%b%b%b, %h}", $time,
				got.arm, got.mode, got.trig_wait, got.source, got.offset,
				exp.arm, exp.mode, exp.trig_wait, exp.source, exp.offset);
		end
	endtask

	task automatic compare_phase(input string what, input ftdi_cmd_pkg::phase_ctrl_t got,
		input ftdi_cmd_pkg::phase_ctrl_t exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("** Error @ %0t: %s got value %h load %b, expected value %h load %b",
				$time, what, got.value, got.load, exp.value, exp.load);
		end
	endtask

	function automatic logic [7:0] returned_byte(input int i);
		if (i < sent_q.size()) return sent_q[i];
		return 8'h00;  // Count mismatch already flagged
	endfunction

	function automatic logic [31:0] returned_word();
		return {returned_byte(3), returned_byte(2), returned_byte(1), returned_byte(0)};  // LSB first
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge ftdi_clk);
	endtask

	// Queue pushes on the rising edge, away from the bridge model
	task automatic send_header(input logic wr, input logic [5:0] addr, input logic [15:0] len);
		@(posedge ftdi_clk);
		host_q.push_back({1'b1, wr, addr});
		host_q.push_back(len[7:0]);
		host_q.push_back(len[15:8]);
	endtask

	// Host bytes drained and bus turned back
	task automatic wait_idle();
		do begin
			@(negedge ftdi_clk);
		end while ((host_q.size() != 0) || isout_o);
		@(negedge ftdi_clk);  // Register outputs one cycle after the last byte
	endtask

	task automatic wait_output();
		do begin
			@(negedge ftdi_clk);
		end while (!isout_o);
	endtask

	task automatic write_reg(input logic [5:0] addr, input logic [15:0] len,
		input logic [31:0] value, input int nbytes);
		send_header(1'b1, addr, len);
		for (int i = 0; i < nbytes; i++) host_q.push_back((i < 4) ? value[i*8 +: 8] : 8'h00);
		wait_idle();
	endtask

	task automatic read_reg(input logic [5:0] addr, input logic [15:0] len, input int nbytes);
		sent_q.delete();
		send_header(1'b0, addr, len);
		wait_idle();
		compare_word("returned byte count", sent_q.size(), nbytes);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, err_cnt - errs_before);
	endtask

	task automatic test_gain_echo();
		int errs;
		errs = err_cnt;
		compare_byte("outputs after reset", {2'd0, rd_o, wr_o, isout_o, fifo_rd_o, reset_o,
			phase_o.load}, 8'h00);
		write_reg(`GAIN_ADDR, 16'd0, 32'h5A, 1);
		write_reg(`ECHO_ADDR, 16'd0, 32'h3C, 1);
		compare_byte("gain_o", gain_o, 8'h5A);
		read_reg(`GAIN_ADDR, 16'd0, 1);
		compare_byte("gain readback", returned_byte(0), 8'h5A);
		read_reg(`ECHO_ADDR, 16'd0, 1);
		compare_byte("echo readback", returned_byte(0), 8'h3C);
		sent_q.delete();
		@(posedge ftdi_clk);
		host_q.push_back({2'b00, `ECHO_ADDR});  // Valid bit clear
		host_q.push_back(8'h00);                 // Length of a read, if the header were kept
		host_q.push_back(8'h00);
		wait_idle();
		compare_word("bytes after dropped header", sent_q.size(), 0);
		read_reg(`ECHO_ADDR, 16'd0, 1);
		compare_byte("echo after dropped header", returned_byte(0), 8'h3C);
		finish_test("gain_echo", errs);
	endtask

	task automatic test_samples();
		int errs;
		errs = err_cnt;
		read_reg(`SAMPLES_ADDR, 16'd0, 4);
		compare_word("samples after reset", returned_word(), MAXSAMPLES_A);
		write_reg(`SAMPLES_ADDR, 16'd4, 32'h00C0_FFEE, 4);
		compare_word("maxsamples_o", maxsamples_o, 32'h00C0_FFEE);
		read_reg(`SAMPLES_ADDR, 16'd0, 4);
		compare_word("samples readback", returned_word(), 32'h00C0_FFEE);
		finish_test("samples", errs);
	endtask

	task automatic test_settings();
		int                       errs;
		ftdi_cmd_pkg::trig_ctrl_t exp_trig;
		errs = err_cnt;
		// 0xEA sets source, ADC clock, wait, arm and hilow
		write_reg(`SETTINGS_ADDR, 16'd0, 32'hEA, 1);
		write_reg(`OFFSET_ADDR, 16'd0, 32'h0000_1F40, 4);
		exp_trig.arm       = 1'b1;
		exp_trig.mode      = 1'b0;
		exp_trig.trig_wait = 1'b1;
		exp_trig.source    = 1'b1;
		exp_trig.offset    = 32'h0000_1F40;
		compare_byte("hilow_o", {7'd0, hilow_o}, 8'h01);
		compare_byte("adc_clk_src_o", {7'd0, adc_clk_src_o}, 8'h01);
		compare_trig(trig_o, exp_trig);
		read_reg(`SETTINGS_ADDR, 16'd0, 1);
		compare_byte("settings readback", returned_byte(0), 8'hEA);
		read_reg(`STATUS_ADDR, 16'd0, 1);
		compare_byte("status", returned_byte(0), 8'hA5);
		status_i = 8'h96;
		read_reg(`STATUS_ADDR, 16'd0, 1);
		compare_byte("status after change", returned_byte(0), 8'h96);
		finish_test("settings", errs);
	endtask

	task automatic test_extfreq();
		int errs;
		errs = err_cnt;
		extclk_freq_i = 32'h0BEB_C200;
		sent_q.delete();
		send_header(1'b0, `EXTFREQ_ADDR, 16'd0);
		wait_output();
		extclk_freq_i = 32'hDEAD_BEEF;  // Mid read, must not show up
		wait_idle();
		compare_word("extfreq byte count", sent_q.size(), 4);
		compare_word("extfreq snapshot", returned_word(), 32'h0BEB_C200);
		read_reg(`ECHO_ADDR, 16'd6, 6);
		compare_byte("echo byte 0", returned_byte(0), 8'h3C);
		for (int i = 1; i < 6; i++) compare_byte("echo pad byte", returned_byte(i), 8'h00);
		finish_test("extfreq", errs);
	endtask

	task automatic test_adc_stream();
		int          errs;
		logic [7:0]  exp_q[$];
		logic [31:0] rnd;
		errs = err_cnt;
		@(posedge ftdi_clk);
		for (int i = 0; i < 5; i++) begin
			rnd = next_rand();
			exp_q.push_back(rnd[23:16]);
			adc_q.push_back(rnd[23:16]);
		end
		read_reg(`ADCDATA_ADDR, 16'd2, 5);  // Length field ignored
		for (int i = 0; i < 5; i++) compare_byte("adc sample", returned_byte(i), exp_q[i]);
		compare_word("samples left in FIFO", adc_q.size(), 0);
		finish_test("adc_stream", errs);
	endtask

	task automatic test_phase_soft();
		int                        errs;
		int                        loads;
		int                        softs;
		ftdi_cmd_pkg::phase_ctrl_t exp_ph;
		ftdi_cmd_pkg::trig_ctrl_t  exp_trig;
		errs  = err_cnt;
		loads = load_cnt;
		softs = soft_cnt;
		write_reg(`PHASE_ADDR, 16'd0, 32'h0334, 2);  // 9'h134, byte 1 bit 1 loads
		wait_cycles(1);
		compare_word("phase load pulses", load_cnt - loads, 1);
		exp_ph.value = 9'h134;
		exp_ph.load  = 1'b1;
		compare_phase("phase at load", load_seen, exp_ph);
		exp_ph.load  = 1'b0;
		compare_phase("phase after load", phase_o, exp_ph);
		phase_i      = 9'h1A7;
		phase_done_i = 1'b1;
		wait_cycles(1);
		phase_done_i = 1'b0;
		read_reg(`PHASE_ADDR, 16'd0, 2);
		compare_byte("phase readback low", returned_byte(0), 8'hA7);
		compare_byte("phase readback high", returned_byte(1), 8'h03);  // Done, bit 8
		maxsamples_i = MAXSAMPLES_B;
		write_reg(`SETTINGS_ADDR, 16'd0, 32'h01, 1);
		wait_cycles(3);  // reset_o, then registers cleared
		compare_word("reset_o pulses", soft_cnt - softs, 1);
		compare_byte("gain_o after soft reset", gain_o, 8'h00);
		compare_word("maxsamples_o after soft reset", maxsamples_o, MAXSAMPLES_B);
		exp_trig = '0;
		compare_trig(trig_o, exp_trig);
		read_reg(`SETTINGS_ADDR, 16'd0, 1);
		compare_byte("settings after soft reset", returned_byte(0), 8'h00);
		finish_test("phase_soft", errs);
	endtask

	initial begin : main
		reset         = 1'b1;
		status_i      = 8'hA5;
		extclk_freq_i = 32'h0BEB_C200;
		maxsamples_i  = MAXSAMPLES_A;
		phase_i       = '0;
		phase_done_i  = 1'b0;
		repeat (10) @(negedge ftdi_clk);
		reset = 1'b0;
		wait_cycles(2);
		test_gain_echo();
		test_samples();
		test_settings();
		test_extfreq();
		test_adc_stream();
		test_phase_soft();
		$display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t, a transfer never completed", $time);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/ftdi_cmd_pkg.sv
hdl/cmd_fsm.sv
hdl/byte_counter.sv
hdl/ctrl_regs.sv
hdl/usb_cmd_top.sv
verification/usb_cmd_asserts.sv
verification/usb_cmd_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= usb_cmd_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= ** FAIL **
PASS_MSG  ?= ** PASS **

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF -- '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF -- '$(PASS_MSG)' $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
